/* common/prf_macros.svh */
`ifndef PRF_MACROS_SVH
`define PRF_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Physical register file sizing
////////////////////////////////////////////////////////////////////////////

// Number of physical registers, a power of two
`define PRF_NUM_ENTRIES 32

// Width of one register value
`define PRF_DATA_WIDTH 64

// Bits to name one entry, 5 for 32 entries
`define PRF_TAG_WIDTH $clog2(`PRF_NUM_ENTRIES)

// Delay on register assignments
// Left empty so the same text builds for synthesis
`define SD

`endif

/* common/prf_pkg.sv */
`include "prf_macros.svh"

package prf_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Types shared by the register file blocks
	////////////////////////////////////////////////////////////////////////////

	// Name of one physical register
	typedef logic [`PRF_TAG_WIDTH-1:0] prf_tag_t;

	// One register value
	typedef logic [`PRF_DATA_WIDTH-1:0] prf_data_t;

	// One bit per entry
	// Carries the available vector from array to free selector
	typedef logic [`PRF_NUM_ENTRIES-1:0] prf_mask_t;

endpackage

/* prf/prf_one_entry.sv */
`timescale 1ns/1ps
`include "prf_macros.svh"

module prf_one_entry
(
	input  logic                clock,
	input  logic                reset,
	input  prf_pkg::prf_data_t  data_in,
	input  logic                write_enable,
	input  logic                allocate,
	input  logic                release_enable,
	output logic                available,
	output logic                ready,
	output prf_pkg::prf_data_t  data_out
);

	import prf_pkg::*;

	// Entry state
	logic       in_use;
	logic       is_valid;
	prf_data_t  value;

	////////////////////////////////////////////////////////////////////////////
	// Flag update
	////////////////////////////////////////////////////////////////////////////

	// Later assignments win
	// Release first, then allocate, then write
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use   <= `SD 1'b0;
			is_valid <= `SD 1'b0;
		end
		else
		begin
			// Retired mapping hands the register back
			if (release_enable)
			begin
				in_use   <= `SD 1'b0;
				is_valid <= `SD 1'b0;
			end
			// Newly renamed, result still pending
			if (allocate)
			begin
				in_use   <= `SD 1'b1;
				is_valid <= `SD 1'b0;
			end
			// Result arrives, so a write in the allocate cycle leaves it valid
			if (write_enable)
				is_valid <= `SD 1'b1;
		end
	end

	// Stored value
	always_ff @(posedge clock)
	begin
		if (write_enable)
			value <= `SD data_in;
	end

	// Status and gated read data
	always_comb
	begin
		available = ~in_use;
		ready     = is_valid;
		// Zero unless live and written
		data_out  = (in_use && is_valid) ? value : '0;
	end

endmodule

/* prf/prf_array.sv */
`timescale 1ns/1ps
`include "prf_macros.svh"

module prf_array
(
	input  logic                clock,
	input  logic                reset,

	// Allocate port
	input  logic                alloc_fire,
	input  prf_pkg::prf_tag_t   alloc_tag,

	// Writeback port
	input  logic                write_enable,
	input  prf_pkg::prf_tag_t   write_tag,
	input  prf_pkg::prf_data_t  write_data,

	// Release port
	input  logic                release_enable,
	input  prf_pkg::prf_tag_t   release_tag,

	// Read ports
	input  prf_pkg::prf_tag_t   read_tag_a,
	input  prf_pkg::prf_tag_t   read_tag_b,
	output prf_pkg::prf_data_t  read_data_a,
	output prf_pkg::prf_data_t  read_data_b,
	output logic                read_ready_a,
	output logic                read_ready_b,

	// Free entries, one bit each
	output prf_pkg::prf_mask_t  available_mask
);

	import prf_pkg::*;

	// Per-entry strobes
	prf_mask_t  alloc_onehot;
	prf_mask_t  write_onehot;
	prf_mask_t  release_onehot;

	// Per-entry outputs
	prf_mask_t  entry_ready;
	prf_data_t  entry_data [`PRF_NUM_ENTRIES];

	////////////////////////////////////////////////////////////////////////////
	// Tag decode
	////////////////////////////////////////////////////////////////////////////

	// Each port strobes at most one entry
	always_comb
	begin
		alloc_onehot   = '0;
		write_onehot   = '0;
		release_onehot = '0;

		if (alloc_fire)
			alloc_onehot[alloc_tag] = 1'b1;

		if (write_enable)
			write_onehot[write_tag] = 1'b1;

		if (release_enable)
			release_onehot[release_tag] = 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Entries
	////////////////////////////////////////////////////////////////////////////

	genvar i;

	for (i = 0; i < `PRF_NUM_ENTRIES; i++)
	begin : g_entry
		// Write data is broadcast, only the strobe is per entry
		prf_one_entry i_entry
		(
			.clock          (clock),
			.reset          (reset),
			.data_in        (write_data),
			.write_enable   (write_onehot[i]),
			.allocate       (alloc_onehot[i]),
			.release_enable (release_onehot[i]),
			.available      (available_mask[i]),
			.ready          (entry_ready[i]),
			.data_out       (entry_data[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Read multiplexers
	////////////////////////////////////////////////////////////////////////////

	// Registered state only, no bypass from this cycle's write
	always_comb
	begin
		read_data_a  = entry_data[read_tag_a];
		read_ready_a = entry_ready[read_tag_a];
	end

	// Second port, independent tag
	always_comb
	begin
		read_data_b  = entry_data[read_tag_b];
		read_ready_b = entry_ready[read_tag_b];
	end

endmodule

/* src/prf_free_select.sv */
`timescale 1ns/1ps
`include "prf_macros.svh"

module prf_free_select
(
	// One bit per free entry
	input  prf_pkg::prf_mask_t      available_mask,

	// Grant candidate
	output logic                    alloc_valid,
	output prf_pkg::prf_tag_t       alloc_tag,

	// Number of free entries, can reach the full count
	output logic [`PRF_TAG_WIDTH:0] free_count
);

	import prf_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Lowest free entry
	////////////////////////////////////////////////////////////////////////////

	// Scan from the top so the lowest set bit is taken last
	always_comb
	begin
		alloc_tag   = '0;
		alloc_valid = 1'b0;

		for (int i = `PRF_NUM_ENTRIES - 1; i >= 0; i--)
		begin
			if (available_mask[i])
			begin
				alloc_tag   = prf_tag_t'(i);
				alloc_valid = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Free entry count
	////////////////////////////////////////////////////////////////////////////

	// Population count of the mask
	// One extra bit so all entries free still fits
	always_comb
	begin
		free_count = '0;

		for (int i = 0; i < `PRF_NUM_ENTRIES; i++)
		begin
			// Zero-extend each bit to the count width
			free_count = free_count + {{`PRF_TAG_WIDTH{1'b0}}, available_mask[i]};
		end
	end

endmodule

/* src/prf_top.sv */
`timescale 1ns/1ps
`include "prf_macros.svh"

module prf_top
(
	input  logic                    clock,
	input  logic                    reset,

	// Allocation, request held as a level
	input  logic                    alloc_request,
	output logic                    alloc_valid,
	output prf_pkg::prf_tag_t       alloc_tag,
	output logic [`PRF_TAG_WIDTH:0] free_count,

	// Writeback strobe
	input  logic                    write_enable,
	input  prf_pkg::prf_tag_t       write_tag,
	input  prf_pkg::prf_data_t      write_data,

	// Release strobe from retirement
	input  logic                    release_enable,
	input  prf_pkg::prf_tag_t       release_tag,

	// Read port a
	input  prf_pkg::prf_tag_t       read_tag_a,
	output prf_pkg::prf_data_t      read_data_a,
	output logic                    read_ready_a,

	// Read port b
	input  prf_pkg::prf_tag_t       read_tag_b,
	output prf_pkg::prf_data_t      read_data_b,
	output logic                    read_ready_b
);

	import prf_pkg::*;

	// Free entries back to the selector
	prf_mask_t  available_mask;

	// Grant taken this cycle
	logic       alloc_fire;

	// A request with no free entry just waits
	assign alloc_fire = alloc_request & alloc_valid;

	////////////////////////////////////////////////////////////////////////////
	// Free entry selection
	////////////////////////////////////////////////////////////////////////////

	prf_free_select i_free_select
	(
		.available_mask (available_mask),
		.alloc_valid    (alloc_valid),
		.alloc_tag      (alloc_tag),
		.free_count     (free_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// Register storage
	////////////////////////////////////////////////////////////////////////////

	prf_array i_array
	(
		.clock          (clock),
		.reset          (reset),
		.alloc_fire     (alloc_fire),
		.alloc_tag      (alloc_tag),
		.write_enable   (write_enable),
		.write_tag      (write_tag),
		.write_data     (write_data),
		.release_enable (release_enable),
		.release_tag    (release_tag),
		.read_tag_a     (read_tag_a),
		.read_tag_b     (read_tag_b),
		.read_data_a    (read_data_a),
		.read_data_b    (read_data_b),
		.read_ready_a   (read_ready_a),
		.read_ready_b   (read_ready_b),
		.available_mask (available_mask)
	);

endmodule

/* tests/prf_tb.sv */
`timescale 1ns/1ps
`include "prf_macros.svh"

module prf_tb;

	import prf_pkg::*;

	// Run length in cycles, used by the watchdog
	localparam int CLOCK_PERIOD  = 20;
	localparam int RESET_CYCLES  = 8;
	localparam int RANDOM_CYCLES = 400;
	localparam int ALLOC_WAIT    = 40;
	localparam int TEST_CYCLES   = RESET_CYCLES + 4 + 12 + 16 + 20
		+ 3 * `PRF_NUM_ENTRIES + RANDOM_CYCLES;
	localparam int MARGIN_CYCLES = 200;

	// DUT ports
	logic                    clock = 1'b0;
	logic                    reset;
	logic                    alloc_request;
	logic                    alloc_valid;
	prf_tag_t                alloc_tag;
	logic [`PRF_TAG_WIDTH:0] free_count;
	logic                    write_enable;
	prf_tag_t                write_tag;
	prf_data_t               write_data;
	logic                    release_enable;
	prf_tag_t                release_tag;
	prf_tag_t                read_tag_a;
	prf_tag_t                read_tag_b;
	prf_data_t               read_data_a;
	prf_data_t               read_data_b;
	logic                    read_ready_a;
	logic                    read_ready_b;

	// Reference model, one slot per physical register
	logic       m_in_use [`PRF_NUM_ENTRIES];
	logic       m_valid  [`PRF_NUM_ENTRIES];
	prf_data_t  m_value  [`PRF_NUM_ENTRIES];

	// Error counts, one per checking process
	int seed;
	int model_errors;
	int direct_errors;
	int property_errors;
	int tests_passed;
	int tests_failed;
	int test_start_errors;

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	prf_top i_dut
	(
		.clock          (clock),
		.reset          (reset),
		.alloc_request  (alloc_request),
		.alloc_valid    (alloc_valid),
		.alloc_tag      (alloc_tag),
		.free_count     (free_count),
		.write_enable   (write_enable),
		.write_tag      (write_tag),
		.write_data     (write_data),
		.release_enable (release_enable),
		.release_tag    (release_tag),
		.read_tag_a     (read_tag_a),
		.read_data_a    (read_data_a),
		.read_ready_a   (read_ready_a),
		.read_tag_b     (read_tag_b),
		.read_data_b    (read_data_b),
		.read_ready_b   (read_ready_b)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Entries not in use
	function automatic int model_free_count();
		int n;
		n = 0;
		for (int i = 0; i < `PRF_NUM_ENTRIES; i++)
			if (!m_in_use[i])
				n++;
		return n;
	endfunction

	// Lowest free entry, -1 when full
	function automatic int model_lowest_free();
		for (int i = 0; i < `PRF_NUM_ENTRIES; i++)
			if (!m_in_use[i])
				return i;
		return -1;
	endfunction

	// Same edge as the DUT, release then allocate then write
	always @(posedge clock)
	begin : model_update
		int grant;
		grant = model_lowest_free();
		if (reset)
		begin
			for (int i = 0; i < `PRF_NUM_ENTRIES; i++)
			begin
				m_in_use[i] <= 1'b0;
				m_valid[i]  <= 1'b0;
				m_value[i]  <= '0;
			end
		end
		else
		begin
			if (release_enable)
			begin
				m_in_use[release_tag] <= 1'b0;
				m_valid[release_tag]  <= 1'b0;
			end
			if (alloc_request && grant >= 0)
			begin
				m_in_use[grant] <= 1'b1;
				m_valid[grant]  <= 1'b0;
			end
			if (write_enable)
			begin
				m_valid[write_tag] <= 1'b1;
				m_value[write_tag] <= write_data;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////

	function automatic bit values_match(string name, logic [63:0] expected,
		logic [63:0] actual);
		bit ok;
		ok = (expected == actual);
		assert (ok)
		else
			$display("MISMATCH at %0t ns: %s expected %0h actual %0h",
				$time, name, expected, actual);
		return ok;
	endfunction

	// Every output against the model, mid-cycle
	always @(negedge clock)
	begin : output_check
		int        grant;
		prf_data_t exp_a;
		prf_data_t exp_b;
		grant = model_lowest_free();
		exp_a = (m_in_use[read_tag_a] && m_valid[read_tag_a]) ? m_value[read_tag_a] : '0;
		exp_b = (m_in_use[read_tag_b] && m_valid[read_tag_b]) ? m_value[read_tag_b] : '0;
		if (!reset)
		begin
			if (!values_match("free_count", 64'(model_free_count()), 64'(free_count)))
				model_errors++;
			if (!values_match("alloc_valid", 64'(grant >= 0), 64'(alloc_valid)))
				model_errors++;
			if (grant >= 0 && !values_match("alloc_tag", 64'(grant), 64'(alloc_tag)))
				model_errors++;
			if (!values_match("read_data_a", exp_a, read_data_a))
				model_errors++;
			if (!values_match("read_ready_a", 64'(m_valid[read_tag_a]), 64'(read_ready_a)))
				model_errors++;
			if (!values_match("read_data_b", exp_b, read_data_b))
				model_errors++;
			if (!values_match("read_ready_b", 64'(m_valid[read_tag_b]), 64'(read_ready_b)))
				model_errors++;
		end
	end

	// A tag taken at an edge is in use afterwards and not offered again
	assert property (@(posedge clock) disable iff (reset)
		(alloc_request && alloc_valid) |=> (!alloc_valid || alloc_tag != $past(alloc_tag)))
	else
	begin
		$display("At %0t ns a tag granted at the last edge was offered again", $time);
		property_errors++;
	end

	// Watchdog
	initial
	begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not finish",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks, all entered 2 ns after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic expect_direct(string name, logic [63:0] expected, logic [63:0] actual);
		if (!values_match(name, expected, actual))
			direct_errors++;
	endtask

	// Hold the request until granted or timed out
	task automatic request_alloc(output int tag);
		int waited;
		waited = 0;
		tag = -1;
		alloc_request = 1'b1;
		while (!alloc_valid && waited < ALLOC_WAIT)
		begin
			next_cycle();
			waited++;
		end
		if (alloc_valid)
			tag = int'(alloc_tag);
		else
		begin
			$display("Allocation request not granted within %0d cycles", ALLOC_WAIT);
			direct_errors++;
		end
		next_cycle();
		alloc_request = 1'b0;
	endtask

	task automatic write_entry(prf_tag_t tag, prf_data_t data);
		write_enable = 1'b1;
		write_tag    = tag;
		write_data   = data;
		next_cycle();
		write_enable = 1'b0;
	endtask

	task automatic release_entry(prf_tag_t tag);
		release_enable = 1'b1;
		release_tag    = tag;
		next_cycle();
		release_enable = 1'b0;
	endtask

	// Wait to mid-cycle so outputs are settled
	task automatic sample_reads(prf_tag_t tag_a, prf_tag_t tag_b);
		read_tag_a = tag_a;
		read_tag_b = tag_b;
		@(negedge clock);
	endtask

	task automatic begin_test();
		test_start_errors = model_errors + direct_errors + property_errors;
	endtask

	task automatic end_test(int number, string name);
		int errors;
		errors = model_errors + direct_errors + property_errors - test_start_errors;
		if (errors == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("test %0d (%s) finished with %0d errors", number, name, errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : stimulus
		int        granted;
		int        r;
		prf_tag_t  pick;
		prf_data_t d0;
		prf_data_t d1;

		seed            = 32'he6;
		model_errors    = 0;
		direct_errors   = 0;
		property_errors = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		reset           = 1'b1;
		alloc_request   = 1'b0;
		write_enable    = 1'b0;
		write_tag       = '0;
		write_data      = '0;
		release_enable  = 1'b0;
		release_tag     = '0;
		read_tag_a      = '0;
		read_tag_b      = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		reset = 1'b0;

		// All free, nothing readable
		begin_test();
		sample_reads(0, 1);
		expect_direct("free_count", 64'(`PRF_NUM_ENTRIES), 64'(free_count));
		expect_direct("alloc_valid", 64'(1), 64'(alloc_valid));
		expect_direct("alloc_tag", 64'(0), 64'(alloc_tag));
		expect_direct("read_ready_a", 64'(0), 64'(read_ready_a));
		expect_direct("read_data_a", 64'(0), read_data_a);
		expect_direct("read_ready_b", 64'(0), 64'(read_ready_b));
		expect_direct("read_data_b", 64'(0), read_data_b);
		next_cycle();
		end_test(1, "reset state");

		// Back-to-back grants in ascending order
		begin_test();
		for (int i = 0; i < 8; i++)
		begin
			request_alloc(granted);
			expect_direct("granted tag", 64'(i), 64'(granted));
		end
		@(negedge clock);
		expect_direct("free_count", 64'(`PRF_NUM_ENTRIES - 8), 64'(free_count));
		next_cycle();
		end_test(2, "ascending allocation");

		// Unwritten reads zero, written reads back next cycle
		begin_test();
		d0 = {$random(seed), $random(seed)};
		d1 = {$random(seed), $random(seed)};
		sample_reads(0, 1);
		expect_direct("read_ready_a", 64'(0), 64'(read_ready_a));
		expect_direct("read_data_a", 64'(0), read_data_a);
		next_cycle();
		write_entry(0, d0);
		write_entry(1, d1);
		sample_reads(0, 1);
		expect_direct("read_data_a", d0, read_data_a);
		expect_direct("read_data_b", d1, read_data_b);
		expect_direct("read_ready_b", 64'(1), 64'(read_ready_b));
		next_cycle();
		end_test(3, "write then read");

		// Release and reuse of the lowest released tag
		begin_test();
		write_entry(3, d0);
		write_entry(5, d1);
		release_entry(3);
		release_entry(5);
		sample_reads(3, 5);
		expect_direct("read_ready_a", 64'(0), 64'(read_ready_a));
		expect_direct("read_data_b", 64'(0), read_data_b);
		next_cycle();
		request_alloc(granted);
		expect_direct("granted tag", 64'(3), 64'(granted));
		sample_reads(3, 5);
		expect_direct("read_ready_a", 64'(0), 64'(read_ready_a));
		next_cycle();
		write_entry(3, d1);
		sample_reads(3, 5);
		expect_direct("read_data_a", d1, read_data_a);
		next_cycle();
		end_test(4, "release and reuse");

		// Full pool holds off a request
		begin_test();
		while (alloc_valid)
			request_alloc(granted);
		alloc_request = 1'b1;
		repeat (3) next_cycle();
		@(negedge clock);
		expect_direct("alloc_valid", 64'(0), 64'(alloc_valid));
		expect_direct("free_count", 64'(0), 64'(free_count));
		next_cycle();
		release_entry(10);
		@(negedge clock);
		expect_direct("alloc_valid", 64'(1), 64'(alloc_valid));
		expect_direct("alloc_tag", 64'(10), 64'(alloc_tag));
		next_cycle();
		alloc_request = 1'b0;
		end_test(5, "full pool");

		// Mixed traffic, writes and releases only to live entries
		begin_test();
		for (int n = 0; n < RANDOM_CYCLES; n++)
		begin
			r              = $random(seed);
			alloc_request  = r[0];
			write_enable   = 1'b0;
			release_enable = 1'b0;
			pick           = prf_tag_t'(r >> 8);
			if (r[1] && m_in_use[pick])
			begin
				write_enable = 1'b1;
				write_tag    = pick;
				write_data   = {$random(seed), $random(seed)};
			end
			pick = prf_tag_t'(r >> 16);
			if (r[2] && m_in_use[pick] && !(write_enable && write_tag == pick))
			begin
				release_enable = 1'b1;
				release_tag    = pick;
			end
			read_tag_a = prf_tag_t'(r >> 24);
			read_tag_b = prf_tag_t'(r >> 3);
			next_cycle();
		end
		alloc_request  = 1'b0;
		write_enable   = 1'b0;
		release_enable = 1'b0;
		next_cycle();
		next_cycle();
		end_test(6, "random traffic");

		$display("summary: %0d tests ok, %0d tests with errors, %0d check errors",
			tests_passed, tests_failed, model_errors + direct_errors + property_errors);
		if (tests_failed == 0 && model_errors + direct_errors + property_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+common
common/prf_pkg.sv
prf/prf_one_entry.sv
prf/prf_array.sv
src/prf_free_select.sv
src/prf_top.sv
tests/prf_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module prf_tb -f project.f -o prf_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/prf_sim > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
